/* verilog/ex_config.svh */
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// datapath and address width
`define EX_XLEN 32

// rd / rs index width
`define EX_REG_IDX_W 5

// one enable per byte lane of a word
`define EX_BE_W 4

`endif

/* verilog/ex_pkg.sv */
`include "ex_config.svh"

package ex_pkg;

  typedef enum logic [2:0] {
    LOAD_STORE = 3'd0,                       // address calc
    BRANCH     = 3'd1,                       // conditional branch
    REG_REG    = 3'd2,                       // r-type
    REG_IMM    = 3'd3,                       // i-type arith
    LUI        = 3'd4,
    AUIPC      = 3'd5,
    JAL        = 3'd6,
    JALR       = 3'd7
  } alu_op_t;

  typedef enum logic [4:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,  // arith / logic
    BEQ, BNE, BLT, BGE, BLTU, BGEU,                    // compares
    PASS_B,                                            // imm straight through for lui
    LINK                                               // pc + 4 for jal / jalr
  } alu_mode_t;

  typedef struct packed {
    logic [`EX_XLEN-1:0]      result;        // alu output or address
    logic [`EX_XLEN-1:0]      target;        // branch / jump target
    logic                     branch_taken;
    logic [`EX_REG_IDX_W-1:0] rd;
    logic                     reg_write;
    logic                     mem_read;
    logic                     mem_write;
    logic [2:0]               func3;         // access size for the aligner
    logic [`EX_XLEN-1:0]      store_data;    // rs2 unshifted
  } ex_result_t;

  typedef struct packed {
    logic [`EX_XLEN-1:0]      result;
    logic [`EX_XLEN-1:0]      addr;          // word aligned
    logic [`EX_BE_W-1:0]      be;
    logic [`EX_XLEN-1:0]      wdata;         // already in its lane
    logic                     misaligned;
    logic [`EX_REG_IDX_W-1:0] rd;
    logic                     reg_write;
    logic                     mem_read;
    logic                     mem_write;
    logic                     branch_taken;
    logic [`EX_XLEN-1:0]      target;
  } mem_req_t;

endpackage

/* verilog/ex_decode.sv */
`timescale 1ns/1ps
`include "ex_config.svh"

module ex_decode
  import ex_pkg::*;
(
  input  alu_op_t             i_alu_op,
  input  logic [2:0]          i_func3,
  input  logic                i_func7,
  input  logic                i_is_store,
  input  logic [`EX_XLEN-1:0] i_rs2,
  input  logic [`EX_XLEN-1:0] i_imm,
  output alu_mode_t           o_mode,
  output logic [`EX_XLEN-1:0] o_op_b,
  output logic                o_reg_write,
  output logic                o_mem_read,
  output logic                o_mem_write
);

  alu_mode_t arith_mode;                     // shared by r-type and i-type
  logic      use_imm;

  // operand b is the immediate for address calc, i-type, lui, auipc and jalr
  assign use_imm = (i_alu_op == LOAD_STORE) || (i_alu_op == REG_IMM) ||
                   (i_alu_op == LUI) || (i_alu_op == AUIPC) || (i_alu_op == JALR);
  assign o_op_b  = use_imm ? i_imm : i_rs2;

  always_comb
  begin
    case (i_func3)
      3'd0:    arith_mode = (i_func7 && i_alu_op == REG_REG) ? SUB : ADD;  // no subi
      3'd1:    arith_mode = SLL;
      3'd2:    arith_mode = SLT;
      3'd3:    arith_mode = SLTU;
      3'd4:    arith_mode = XOR;
      3'd5:    arith_mode = i_func7 ? SRA : SRL;   // srai uses the same bit
      3'd6:    arith_mode = OR;
      default: arith_mode = AND;
    endcase
  end

  always_comb
  begin
    o_mode = ADD;                            // load/store and auipc
    case (i_alu_op)
      BRANCH:
      begin
        case (i_func3)
          3'd1:    o_mode = BNE;
          3'd4:    o_mode = BLT;
          3'd5:    o_mode = BGE;
          3'd6:    o_mode = BLTU;
          3'd7:    o_mode = BGEU;
          default: o_mode = BEQ;             // 2 and 3 are unused encodings
        endcase
      end
      REG_REG, REG_IMM: o_mode = arith_mode;
      LUI:              o_mode = PASS_B;
      JAL, JALR:        o_mode = LINK;
      default:          o_mode = ADD;
    endcase
  end

  // branches and stores write nothing back
  assign o_reg_write = (i_alu_op != BRANCH) && !(i_alu_op == LOAD_STORE && i_is_store);
  assign o_mem_read  = (i_alu_op == LOAD_STORE) && !i_is_store;
  assign o_mem_write = (i_alu_op == LOAD_STORE) && i_is_store;

endmodule

/* verilog/ex_alu.sv */
`timescale 1ns/1ps
`include "ex_config.svh"

module ex_alu
  import ex_pkg::*;
(
  input  alu_mode_t           i_mode,
  input  logic [`EX_XLEN-1:0] i_a,            // rs1 or pc for auipc
  input  logic [`EX_XLEN-1:0] i_b,            // rs2 or imm
  input  logic [`EX_XLEN-1:0] i_pc,
  input  logic [`EX_XLEN-1:0] i_imm,          // already scaled
  input  logic                i_is_jalr,
  output logic [`EX_XLEN-1:0] o_result,
  output logic                o_branch_taken,
  output logic [`EX_XLEN-1:0] o_target
);

  localparam logic [`EX_XLEN-1:0] PC_STEP = `EX_XLEN'(4);

  logic [4:0]          shamt;
  logic                eq;
  logic                lt_s;
  logic                lt_u;
  logic [`EX_XLEN-1:0] jalr_sum;

  assign shamt = i_b[4:0];                    // rv32 uses the low five bits
  assign eq    = (i_a == i_b);
  assign lt_s  = ($signed(i_a) < $signed(i_b));
  assign lt_u  = (i_a < i_b);

  // jalr clears bit 0 of rs1 + imm while the rest are pc relative
  assign jalr_sum = i_a + i_imm;
  assign o_target = i_is_jalr ? {jalr_sum[`EX_XLEN-1:1], 1'b0} : (i_pc + i_imm);

  always_comb
  begin
    case (i_mode)
      BEQ:     o_branch_taken = eq;
      BNE:     o_branch_taken = !eq;
      BLT:     o_branch_taken = lt_s;
      BGE:     o_branch_taken = !lt_s;
      BLTU:    o_branch_taken = lt_u;
      BGEU:    o_branch_taken = !lt_u;
      default: o_branch_taken = 1'b0;        // not a compare
    endcase
  end

  always_comb
  begin
    case (i_mode)
      ADD:     o_result = i_a + i_b;
      SUB:     o_result = i_a - i_b;
      SLL:     o_result = i_a << shamt;
      SLT:     o_result = {{(`EX_XLEN-1){1'b0}}, lt_s};
      SLTU:    o_result = {{(`EX_XLEN-1){1'b0}}, lt_u};
      XOR:     o_result = i_a ^ i_b;
      SRL:     o_result = i_a >> shamt;
      SRA:     o_result = $unsigned($signed(i_a) >>> shamt);   // sign fill
      OR:      o_result = i_a | i_b;
      AND:     o_result = i_a & i_b;
      PASS_B:  o_result = i_b;
      LINK:    o_result = i_pc + PC_STEP;    // return address
      BEQ, BNE, BLT, BGE, BLTU, BGEU:
               o_result = o_target;          // branch reports its target
      default: o_result = '0;
    endcase
  end

endmodule

/* verilog/ex_pipe_reg.sv */
`timescale 1ns/1ps

module ex_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     i_clk,
  input  logic     i_rst_n,
  input  logic     i_hold,                    // downstream stall
  input  logic     i_valid,
  input  payload_t i_data,
  output logic     o_valid,
  output payload_t o_data
);

  // valid bit clears on reset
  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      o_valid <= 1'b0;
    end
    else if (!i_hold)
    begin
      o_valid <= i_valid;                     // bubble drops in when upstream idle
    end
  end

  // payload only loads on a real transfer
  always_ff @(posedge i_clk)
  begin
    if (!i_hold && i_valid)
    begin
      o_data <= i_data;
    end
  end

endmodule

/* verilog/mem_lane_align.sv */
`timescale 1ns/1ps
`include "ex_config.svh"

module mem_lane_align
  import ex_pkg::*;
(
  input  ex_result_t i_res,
  output mem_req_t   o_req
);

  logic [1:0]          offset;
  logic [`EX_BE_W-1:0] be_base;
  logic                access;
  logic                misaligned;

  assign offset = i_res.result[1:0];          // byte within the word
  assign access = i_res.mem_read || i_res.mem_write;

  always_comb
  begin
    case (i_res.func3[1:0])                    // bit 2 is the unsigned load flag
      2'b00:   be_base = 4'b0001;              // byte
      2'b01:   be_base = 4'b0011;              // half
      2'b10:   be_base = 4'b1111;              // word
      default: be_base = 4'b0000;              // no such size
    endcase
  end

  // half must sit on an even byte and word on offset 0
  assign misaligned = access &&
                      (((i_res.func3[1:0] == 2'b01) && offset[0]) ||
                       ((i_res.func3[1:0] == 2'b10) && (offset != 2'b00)));

  always_comb
  begin
    o_req.result       = i_res.result;
    o_req.addr         = {i_res.result[`EX_XLEN-1:2], 2'b00};
    o_req.be           = (access && !misaligned) ? (be_base << offset) : '0;
    o_req.wdata        = i_res.store_data << {offset, 3'b000};   // into the lane
    o_req.misaligned   = misaligned;
    o_req.rd           = i_res.rd;
    o_req.reg_write    = i_res.reg_write;
    o_req.mem_read     = i_res.mem_read;
    o_req.mem_write    = i_res.mem_write;
    o_req.branch_taken = i_res.branch_taken;
    o_req.target       = i_res.target;
  end

endmodule

/* verilog/ex_stage_top.sv */
`timescale 1ns/1ps
`include "ex_config.svh"

module ex_stage_top
  import ex_pkg::*;
(
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  logic                     i_valid,
  input  logic                     i_stall,       // back-pressure from mem
  input  logic [`EX_XLEN-1:0]      i_pc,
  input  logic [`EX_XLEN-1:0]      i_rs1,
  input  logic [`EX_XLEN-1:0]      i_rs2,
  input  logic [`EX_XLEN-1:0]      i_imm,
  input  alu_op_t                  i_alu_op,
  input  logic [2:0]               i_func3,
  input  logic                     i_func7,
  input  logic [`EX_REG_IDX_W-1:0] i_rd,
  input  logic                     i_is_store,
  output logic                     o_ready,
  output logic                     o_valid,
  output logic [`EX_XLEN-1:0]      o_result,
  output logic [`EX_REG_IDX_W-1:0] o_rd,
  output logic                     o_reg_write,
  output logic                     o_branch_taken,
  output logic [`EX_XLEN-1:0]      o_target,
  output logic                     o_mem_read,
  output logic                     o_mem_write,
  output logic [`EX_XLEN-1:0]      o_mem_addr,
  output logic [`EX_BE_W-1:0]      o_mem_be,
  output logic [`EX_XLEN-1:0]      o_mem_wdata,
  output logic                     o_mem_misaligned
);

  alu_mode_t           mode;
  logic [`EX_XLEN-1:0] op_a;
  logic [`EX_XLEN-1:0] op_b;
  logic [`EX_XLEN-1:0] alu_result;
  logic [`EX_XLEN-1:0] alu_target;
  logic                alu_taken;
  logic                dec_reg_write;
  logic                dec_mem_read;
  logic                dec_mem_write;
  ex_result_t          ex_res;
  ex_result_t          ex_q;                  // stage 1
  logic                ex_valid;
  mem_req_t            mem_req;
  mem_req_t            mem_q;                 // stage 2

  assign o_ready = !i_stall;                  // both stages move together
  assign op_a    = (i_alu_op == AUIPC) ? i_pc : i_rs1;

  ex_decode u_decode (
    .i_alu_op    (i_alu_op),
    .i_func3     (i_func3),
    .i_func7     (i_func7),
    .i_is_store  (i_is_store),
    .i_rs2       (i_rs2),
    .i_imm       (i_imm),
    .o_mode      (mode),
    .o_op_b      (op_b),
    .o_reg_write (dec_reg_write),
    .o_mem_read  (dec_mem_read),
    .o_mem_write (dec_mem_write)
  );

  ex_alu u_alu (
    .i_mode         (mode),
    .i_a            (op_a),
    .i_b            (op_b),
    .i_pc           (i_pc),
    .i_imm          (i_imm),
    .i_is_jalr      (i_alu_op == JALR),
    .o_result       (alu_result),
    .o_branch_taken (alu_taken),
    .o_target       (alu_target)
  );

  always_comb
  begin
    ex_res.result       = alu_result;
    ex_res.target       = alu_target;
    ex_res.branch_taken = alu_taken;
    ex_res.rd           = i_rd;
    ex_res.reg_write    = dec_reg_write;
    ex_res.mem_read     = dec_mem_read;
    ex_res.mem_write    = dec_mem_write;
    ex_res.func3        = i_func3;
    ex_res.store_data   = i_rs2;
  end

  ex_pipe_reg #(.payload_t(ex_result_t)) u_ex_reg (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_hold  (i_stall),
    .i_valid (i_valid),                       // ready is implied by !hold
    .i_data  (ex_res),
    .o_valid (ex_valid),
    .o_data  (ex_q)
  );

  mem_lane_align u_align (
    .i_res (ex_q),
    .o_req (mem_req)
  );

  ex_pipe_reg #(.payload_t(mem_req_t)) u_mem_reg (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_hold  (i_stall),
    .i_valid (ex_valid),
    .i_data  (mem_req),
    .o_valid (o_valid),
    .o_data  (mem_q)
  );

  // control bits qualified so they read low before the first instruction
  assign o_result         = mem_q.result;
  assign o_rd             = mem_q.rd;
  assign o_reg_write      = o_valid && mem_q.reg_write;
  assign o_branch_taken   = o_valid && mem_q.branch_taken;
  assign o_target         = mem_q.target;
  assign o_mem_read       = o_valid && mem_q.mem_read;
  assign o_mem_write      = o_valid && mem_q.mem_write;
  assign o_mem_addr       = mem_q.addr;
  assign o_mem_be         = o_valid ? mem_q.be : '0;
  assign o_mem_wdata      = mem_q.wdata;
  assign o_mem_misaligned = o_valid && mem_q.misaligned;

endmodule

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 20,
  parameter int RST_CYCLES = 3
) (
  output logic o_clk,
  output logic o_rst_n
);

  initial
  begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // flops still see reset low on the releasing edge
  initial
  begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    o_rst_n <= 1'b1;
  end

endmodule

/* tb/ex_stage_assertions.sv */
`timescale 1ns/1ps
`include "ex_config.svh"

module ex_stage_assertions (
  input logic                     i_clk,
  input logic                     i_rst_n,
  input logic                     i_stall,
  input logic                     i_ready,
  input logic                     i_out_valid,
  input logic [`EX_XLEN-1:0]      i_result,
  input logic [`EX_REG_IDX_W-1:0] i_rd,
  input logic                     i_reg_write,
  input logic                     i_branch_taken,
  input logic [`EX_XLEN-1:0]      i_target,
  input logic                     i_mem_read,
  input logic                     i_mem_write,
  input logic [`EX_XLEN-1:0]      i_mem_addr,
  input logic [`EX_BE_W-1:0]      i_mem_be,
  input logic [`EX_XLEN-1:0]      i_mem_wdata,
  input logic                     i_mem_misaligned
);

  // stage 2 frozen while the memory stage stalls
  property p_hold_on_stall;
    @(posedge i_clk) disable iff (!i_rst_n)
      (i_stall && i_out_valid) |=>
        (i_out_valid && $stable(i_result) && $stable(i_rd) && $stable(i_reg_write) &&
         $stable(i_branch_taken) && $stable(i_target) && $stable(i_mem_read) &&
         $stable(i_mem_write) && $stable(i_mem_addr) && $stable(i_mem_be) &&
         $stable(i_mem_wdata) && $stable(i_mem_misaligned));
  endproperty

  a_hold_on_stall: assert property (p_hold_on_stall)
    else $error("stage 2 outputs moved during a stall");

  a_ready_is_not_stall: assert property (@(posedge i_clk) i_ready == !i_stall)
    else $error("o_ready does not follow the inverse of i_stall");

  // nothing in flight on the first edge after reset release
  a_idle_after_reset: assert property (@(posedge i_clk) $rose(i_rst_n) |-> !i_out_valid)
    else $error("o_valid high in the cycle after reset");

endmodule

/* tb/tb_ex_stage.sv */
`timescale 1ns/1ps
`include "ex_config.svh"

module tb_ex_stage
  import ex_pkg::*;
();

  localparam int N_INSTR        = 600;      // first 256 sweep every encoding
  localparam int MAX_STALL      = 3;
  localparam int TIMEOUT_CYCLES = N_INSTR * (2 + MAX_STALL) + 100;

  typedef struct packed {
    int          idx;
    int          acc_edge;                  // edge that accepted it
    int          acc_stalls;                // stalled edges up to then
    logic [31:0] result;
    logic [31:0] target;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
    logic [4:0]  rd;
    logic        reg_write;
    logic        mem_read;
    logic        mem_write;
    logic        branch_taken;
    logic        misaligned;
    logic        chk_result;
    logic        chk_target;
    logic        chk_taken;
    logic        chk_mem;                   // be and misaligned
  } exp_t;

  logic                     clk;
  logic                     rst_n;
  logic                     i_valid;
  logic                     i_stall;
  logic [`EX_XLEN-1:0]      i_pc;
  logic [`EX_XLEN-1:0]      i_rs1;
  logic [`EX_XLEN-1:0]      i_rs2;
  logic [`EX_XLEN-1:0]      i_imm;
  alu_op_t                  i_alu_op;
  logic [2:0]               i_func3;
  logic                     i_func7;
  logic [`EX_REG_IDX_W-1:0] i_rd;
  logic                     i_is_store;
  logic                     o_ready;
  logic                     o_valid;
  logic [`EX_XLEN-1:0]      o_result;
  logic [`EX_REG_IDX_W-1:0] o_rd;
  logic                     o_reg_write;
  logic                     o_branch_taken;
  logic [`EX_XLEN-1:0]      o_target;
  logic                     o_mem_read;
  logic                     o_mem_write;
  logic [`EX_XLEN-1:0]      o_mem_addr;
  logic [`EX_BE_W-1:0]      o_mem_be;
  logic [`EX_XLEN-1:0]      o_mem_wdata;
  logic                     o_mem_misaligned;

  exp_t        exp_q[$];                    // scoreboard with the oldest first
  exp_t        popped;
  exp_t        pushed_exp;
  logic [31:0] lcg_state   = 32'd77501;
  int          errors      = 0;
  int          issued      = 0;
  int          pushed      = 0;
  int          retired     = 0;
  int          stall_left  = 0;
  int          edge_cnt    = 0;
  int          stall_edges = 0;

  tb_clk_gen #(.PERIOD_NS(20), .RST_CYCLES(3)) u_clk_gen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  ex_stage_top DUT (
    .i_clk            (clk),
    .i_rst_n          (rst_n),
    .i_valid          (i_valid),
    .i_stall          (i_stall),
    .i_pc             (i_pc),
    .i_rs1            (i_rs1),
    .i_rs2            (i_rs2),
    .i_imm            (i_imm),
    .i_alu_op         (i_alu_op),
    .i_func3          (i_func3),
    .i_func7          (i_func7),
    .i_rd             (i_rd),
    .i_is_store       (i_is_store),
    .o_ready          (o_ready),
    .o_valid          (o_valid),
    .o_result         (o_result),
    .o_rd             (o_rd),
    .o_reg_write      (o_reg_write),
    .o_branch_taken   (o_branch_taken),
    .o_target         (o_target),
    .o_mem_read       (o_mem_read),
    .o_mem_write      (o_mem_write),
    .o_mem_addr       (o_mem_addr),
    .o_mem_be         (o_mem_be),
    .o_mem_wdata      (o_mem_wdata),
    .o_mem_misaligned (o_mem_misaligned)
  );

  bind ex_stage_top ex_stage_assertions u_assertions (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_stall          (i_stall),
    .i_ready          (o_ready),
    .i_out_valid      (o_valid),
    .i_result         (o_result),
    .i_rd             (o_rd),
    .i_reg_write      (o_reg_write),
    .i_branch_taken   (o_branch_taken),
    .i_target         (o_target),
    .i_mem_read       (o_mem_read),
    .i_mem_write      (o_mem_write),
    .i_mem_addr       (o_mem_addr),
    .i_mem_be         (o_mem_be),
    .i_mem_wdata      (o_mem_wdata),
    .i_mem_misaligned (o_mem_misaligned)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // upper halves only since the low lcg bits cycle fast
  function automatic logic [31:0] rand32();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi[31:16], lo[31:16]};
  endfunction

  // signed compare by flipping the sign bits
  function automatic logic signed_less(input logic [31:0] a, input logic [31:0] b);
    return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
  endfunction

  function automatic logic [31:0] ref_arith(input logic [2:0] f3, input logic sub,
                                            input logic sra, input logic [31:0] a,
                                            input logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];                            // shift amount mod 32
    case (f3)
      3'd0:    return sub ? a - b : a + b;
      3'd1:    return a << sh;
      3'd2:    return {31'd0, signed_less(a, b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return sra ? ((a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0)) : (a >> sh);
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic exp_t predict(input alu_op_t op, input logic [2:0] f3, input logic f7,
                                   input logic st, input logic [31:0] pc,
                                   input logic [31:0] rs1, input logic [31:0] rs2,
                                   input logic [31:0] imm, input logic [4:0] rd);
    exp_t        e;
    logic [31:0] addr;
    logic [1:0]  off;
    e            = '0;
    addr         = rs1 + imm;
    off          = addr[1:0];
    e.rd         = rd;
    e.reg_write  = (op != BRANCH) && !(op == LOAD_STORE && st);
    e.mem_read   = (op == LOAD_STORE) && !st;
    e.mem_write  = (op == LOAD_STORE) && st;
    e.chk_result = 1'b1;
    e.chk_taken  = 1'b1;                    // non-branches never take
    case (op)
      LOAD_STORE:
      begin
        e.result     = addr;
        e.addr       = {addr[31:2], 2'b00};
        e.wdata      = rs2 << (8 * off);
        e.chk_mem    = (f3[1:0] != 2'b11);  // no 64-bit access on rv32
        e.misaligned = (f3[1:0] == 2'b01 && off[0]) || (f3[1:0] == 2'b10 && off != 2'b00);
        if (!e.misaligned)
          e.be = (f3[1:0] == 2'b00) ? (4'b0001 << off) :
                 (f3[1:0] == 2'b01) ? (4'b0011 << off) : 4'b1111;
      end
      BRANCH:
      begin
        e.chk_result = 1'b0;
        e.chk_target = 1'b1;
        e.target     = pc + imm;
        case (f3)
          3'd0:    e.branch_taken = (rs1 == rs2);
          3'd1:    e.branch_taken = (rs1 != rs2);
          3'd4:    e.branch_taken = signed_less(rs1, rs2);
          3'd5:    e.branch_taken = !signed_less(rs1, rs2);
          3'd6:    e.branch_taken = (rs1 < rs2);
          3'd7:    e.branch_taken = (rs1 >= rs2);
          default: e.chk_taken = 1'b0;      // 2 and 3 encode no branch
        endcase
      end
      REG_REG: e.result = ref_arith(f3, f7, f7, rs1, rs2);
      REG_IMM: e.result = ref_arith(f3, 1'b0, f7, rs1, imm);   // no subi
      LUI:     e.result = imm;
      AUIPC:   e.result = pc + imm;
      default:                              // jal, jalr
      begin
        e.result     = pc + 32'd4;
        e.chk_target = 1'b1;
        e.target     = (op == JALR) ? (addr & ~32'd1) : (pc + imm);
      end
    endcase
    return e;
  endfunction

  task automatic check_field(input int idx, input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("ERROR instr %0d %s: got 0x%08h expected 0x%08h", idx, name, got, exp);
    end
  endtask

  task automatic drive_instr(input int idx);
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] pc;
    logic [2:0]  op;
    logic [2:0]  f3;
    logic        f7;
    logic        st;
    r   = rand32();
    a   = rand32();
    b   = rand32();
    imm = rand32();
    pc  = rand32();
    if (idx < 256)
      {op, f3, f7, st} = idx[7:0];          // class, func3, func7, store sweep
    else
      {op, f3, f7, st} = r[7:0];
    case (r[9:8])
      2'd0:    b = a;                       // equal operands
      2'd1:
      begin
        a = {{24{a[7]}}, a[7:0]};           // small values around zero
        b = {{24{b[7]}}, b[7:0]};
      end
      default: ;
    endcase
    case (alu_op_t'(op))
      BRANCH, JAL: imm = {{19{imm[12]}}, imm[12:1], 1'b0};   // scaled and even
      LUI:         imm = {imm[31:12], 12'd0};
      default:     imm = {{20{imm[11]}}, imm[11:0]};
    endcase
    i_valid    <= 1'b1;
    i_alu_op   <= alu_op_t'(op);
    i_func3    <= f3;
    i_func7    <= f7;
    i_is_store <= st;
    i_rs1      <= a;
    i_rs2      <= b;
    i_imm      <= imm;
    i_pc       <= {pc[31:2], 2'b00};
    i_rd       <= r[14:10];
  endtask

  // stall runs of 1..MAX_STALL cycles with a free cycle between runs
  task automatic drive_stall();
    logic [31:0] r;
    r = rand32();
    if (stall_left > 0)
    begin
      i_stall <= 1'b1;
      stall_left--;
    end
    else if (!i_stall && r[1:0] == 2'b00)
    begin
      i_stall    <= 1'b1;
      stall_left = r[9:8] % MAX_STALL;
    end
    else
      i_stall <= 1'b0;
  endtask

  always @(posedge clk)
  begin
    edge_cnt <= edge_cnt + 1;
    if (i_stall)
      stall_edges <= stall_edges + 1;
  end

  // handshake for the coming edge is settled at the negedge
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (o_ready !== !i_stall)
      begin
        errors++;
        $display("ERROR o_ready: got 0x%0h expected 0x%0h", o_ready, !i_stall);
      end
      if (o_valid && !i_stall)              // leaves at the next edge
      begin
        if (exp_q.size() == 0)
        begin
          errors++;
          $display("o_valid high with no instruction in flight");
        end
        else
        begin
          popped = exp_q.pop_front();
          check_field(popped.idx, "o_reg_write", o_reg_write, popped.reg_write);
          check_field(popped.idx, "o_mem_read", o_mem_read, popped.mem_read);
          check_field(popped.idx, "o_mem_write", o_mem_write, popped.mem_write);
          if (popped.chk_taken)
            check_field(popped.idx, "o_branch_taken", o_branch_taken, popped.branch_taken);
          if (popped.chk_result)
            check_field(popped.idx, "o_result", o_result, popped.result);
          if (popped.chk_target)
            check_field(popped.idx, "o_target", o_target, popped.target);
          if (popped.reg_write)
            check_field(popped.idx, "o_rd", o_rd, popped.rd);
          if (popped.mem_read || popped.mem_write)
            check_field(popped.idx, "o_mem_addr", o_mem_addr, popped.addr);
          if (popped.mem_write)
            check_field(popped.idx, "o_mem_wdata", o_mem_wdata, popped.wdata);
          if (popped.chk_mem)
            check_field(popped.idx, "o_mem_be", o_mem_be, popped.be);
          if (popped.chk_mem)
            check_field(popped.idx, "o_mem_misaligned", o_mem_misaligned, popped.misaligned);
          if ((edge_cnt + 1 - popped.acc_edge) != (2 + stall_edges - popped.acc_stalls))
          begin
            errors++;
            $display("instruction %0d came out after the wrong number of cycles", popped.idx);
          end
          retired++;
        end
      end
      if (i_valid && o_ready)               // accepted at the next edge
      begin
        pushed_exp = predict(i_alu_op, i_func3, i_func7, i_is_store, i_pc, i_rs1, i_rs2,
                             i_imm, i_rd);
        pushed_exp.idx        = pushed;
        pushed_exp.acc_edge   = edge_cnt + 1;
        pushed_exp.acc_stalls = stall_edges;
        exp_q.push_back(pushed_exp);
        pushed++;
      end
    end
  end

  initial
  begin
    i_valid    = 1'b0;
    i_stall    = 1'b0;
    i_pc       = '0;
    i_rs1      = '0;
    i_rs2      = '0;
    i_imm      = '0;
    i_alu_op   = LOAD_STORE;
    i_func3    = '0;
    i_func7    = 1'b0;
    i_rd       = '0;
    i_is_store = 1'b0;
    wait (rst_n === 1'b1);
    @(negedge clk);
    if (o_valid || o_reg_write || o_mem_read || o_mem_write || o_branch_taken ||
        o_mem_misaligned || o_mem_be != '0)
    begin
      errors++;
      $display("control outputs not low after reset");
    end
    @(posedge clk);
    drive_instr(0);
    while (issued < N_INSTR)
    begin
      @(posedge clk);
      if (i_valid && o_ready)               // taken on this edge
      begin
        issued++;
        if (issued < N_INSTR)
          drive_instr(issued);
        else
          i_valid <= 1'b0;
      end
      drive_stall();
    end
    i_stall <= 1'b0;                        // drain
    while (retired < N_INSTR)
    begin
      @(posedge clk);
    end
    repeat (3) @(posedge clk);              // catch stray valids
    $display("%0d of %0d instructions retired, %0d errors", retired, N_INSTR, errors);
    if (errors == 0 && exp_q.size() == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  initial
  begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout after %0d cycles with %0d of %0d instructions retired",
             TIMEOUT_CYCLES, retired, N_INSTR);
    $display("Test failures found");
    $finish;
  end

endmodule

/* sources.f */
+incdir+verilog
verilog/ex_pkg.sv
verilog/ex_decode.sv
verilog/ex_alu.sv
verilog/ex_pipe_reg.sv
verilog/mem_lane_align.sv
verilog/ex_stage_top.sv
tb/tb_clk_gen.sv
tb/ex_stage_assertions.sv
tb/tb_ex_stage.sv

/* Bender.yml */
package:
  name: ex_stage

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ex_pkg.sv
      - verilog/ex_decode.sv
      - verilog/ex_alu.sv
      - verilog/ex_pipe_reg.sv
      - verilog/mem_lane_align.sv
      - verilog/ex_stage_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/tb_clk_gen.sv
      - tb/ex_stage_assertions.sv
      - tb/tb_ex_stage.sv
